//--- Makefile
.PHONY: all lint clean

all:
	verilator --binary --timing --assert -Wno-fatal -f filelist.f \
		--top-module tb_naxi_monitor -Mdir obj_dir -o sim_naxi
	./obj_dir/sim_naxi | tee sim.log
	grep -q "TEST OK" sim.log

lint:
	verilator --lint-only -Wall --timing -f filelist.f --top-module naxi_protocol_monitor

clean:
	rm -rf obj_dir sim.log

//--- filelist.f
verilog/naxi_pkg.sv
verilog/naxi_cmd_check.sv
verilog/naxi_pending_table.sv
verilog/naxi_wdata_track.sv
verilog/naxi_resp_track.sv
verilog/naxi_error_log.sv
verilog/naxi_protocol_monitor.sv
verification/tb_naxi_monitor.sv

//--- verification/tb_naxi_monitor.sv
`timescale 1ns/1ps

module tb_naxi_monitor;

  import naxi_pkg::*;

  localparam int LEGAL_CYCLES  = 2000;
  localparam int DIRECT_CYCLES = 16;
  localparam int DATA_CYCLES   = 300;
  localparam int RESP_CYCLES   = 300;
  localparam int MIXED_CYCLES  = 1000;
  localparam int DRAIN_CYCLES  = 10;
  localparam int LIMIT_CYCLES  = LEGAL_CYCLES + DIRECT_CYCLES + DATA_CYCLES + RESP_CYCLES +
                                 MIXED_CYCLES + 4 * DRAIN_CYCLES + 100;

  logic clk;
  logic rst;
  logic s_creq_valid, s_creq_rdstall, s_creq_wrstall;
  logic [TYPE_W-1:0] s_creq_type;
  logic [ATTR_W-1:0] s_creq_attr;
  logic [SIZE_W-1:0] s_creq_size;
  logic [ID_W-1:0] s_creq_id;
  logic [ADDR_W-1:0] s_creq_addr;
  logic s_dreq_valid, s_dreq_stall, s_rreq_valid, s_rreq_stall;
  logic [ID_W-1:0] s_dreq_id, s_rreq_id;
  logic [ATTR_W-1:0] s_dreq_attr, s_rreq_attr;
  logic [NUM_ERR-1:0] err_pulse;
  logic err_sticky;
  logic [CNT_W-1:0] err_count;

  logic [NUM_ERR-1:0] exp_q, seen_bits;
  string exp_name, phase_name;
  bit have_exp;
  int model_count, gen_wrem, gen_rrem;
  int cycle_cnt = 0;
  logic [ID_W-1:0] gen_wid, gen_rid;

  // Reference model state
  logic m_vld [NUM_ID];
  logic m_ack [NUM_ID];
  logic m_rd [NUM_ID];
  logic [BCNT_W-1:0] m_bcnt [NUM_ID];
  logic [BCNT_W-1:0] m_wrem, m_rrem;
  logic [ID_W-1:0] m_wid, m_rid;

  naxi_protocol_monitor uut (.*);

  always #10 clk = ~clk;

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= LIMIT_CYCLES) stop_with_message("Timeout: run went past its cycle limit");
  end

  task automatic stop_on_mismatch(input string name, input logic [31:0] exp_v,
                                  input logic [31:0] act_v);
    $display("CHECK FAILED: %s expected %0h actual %0h", name, exp_v, act_v);
    $display("TEST FAILED");
    $fatal(1, "mismatch in %s", name);
  endtask

  task automatic stop_with_message(input string msg);
    $display("%s", msg);
    $display("TEST FAILED");
    $fatal(1, "%s", msg);
  endtask

  task automatic clear_inputs();
    {s_creq_valid, s_creq_rdstall, s_creq_wrstall, s_dreq_valid, s_dreq_stall} = '0;
    {s_creq_type, s_creq_attr, s_creq_size, s_creq_id, s_creq_addr} = '0;
    {s_dreq_id, s_dreq_attr, s_rreq_valid, s_rreq_id, s_rreq_attr, s_rreq_stall} = '0;
  endtask

  // --------------------------------------------------------------------------
  // Expected error vector of the cycle being driven, then next model state
  // --------------------------------------------------------------------------
  task automatic model_step(output logic [NUM_ERR-1:0] e);
    logic is_wr, is_mt, wstart, wbeat, w_in, w_final, rbeat, r_in, pv, pa, pr;
    logic [BCNT_W-1:0] bc, pb, r_next;
    int ofs_l;
    is_wr = (s_creq_type == TYPE_WRITE);
    is_mt = (s_creq_type == TYPE_FLUSH) || (s_creq_type == TYPE_INVAL);
    ofs_l = int'(s_creq_addr[LINE_OFS_W-1:0]);
    bc = BCNT_W'((int'(s_creq_addr[BYTE_OFS_W-1:0]) + int'(s_creq_size) + BEAT_BYTES - 1)
                 / BEAT_BYTES);
    e = '0;
    if (s_creq_valid) begin
      e[ERR_TYPE]           = (s_creq_type > TYPE_INVAL);
      e[ERR_WR_NO_DATA]     = is_wr && (!s_dreq_valid || s_dreq_id != s_creq_id);
      e[ERR_DATA_NONWR]     = !is_wr && s_dreq_valid;
      e[ERR_MAINT_ALIGN]    = is_mt && (ofs_l != 0);
      e[ERR_MAINT_UNCACHED] = is_mt && !s_creq_attr[CMD_CACHE];
      e[ERR_PREFIX]         = s_creq_attr[CMD_CACHE] && (s_creq_addr[ADDR_W-1 -: PREFIX_W] != 0);
      e[ERR_SIZE]           = (s_creq_size == 0) || (ofs_l + int'(s_creq_size) > LINE_BYTES);
    end
    e[ERR_STALL_MIX] = (s_creq_rdstall || s_creq_wrstall || s_dreq_stall) &&
                       !(s_creq_rdstall && s_creq_wrstall && s_dreq_stall);
    wstart  = s_creq_valid && is_wr && s_dreq_valid && !e[ERR_STALL_MIX] && !s_dreq_stall;
    wbeat   = s_dreq_valid && !s_dreq_stall;
    w_in    = (m_wrem != 0);
    w_final = wstart ? (bc == 1) : (m_wrem == 1);
    e[ERR_DATA_NO_LAST] = wbeat && w_final && !s_dreq_attr[ATTR_LAST];
    e[ERR_DATA_ID]      = s_dreq_valid && w_in && !wstart && (s_dreq_id != m_wid);
    pv = m_vld[s_rreq_id];
    pa = m_ack[s_rreq_id];
    pr = m_rd[s_rreq_id];
    pb = m_bcnt[s_rreq_id];
    rbeat  = s_rreq_valid && !s_rreq_stall;
    r_in   = (m_rrem != 0);
    r_next = m_rrem;
    if (rbeat && !r_in) r_next = (pv && pr && pb != 0) ? pb - 1 : 0;
    else if (rbeat) r_next = m_rrem - 1;
    e[ERR_RESP_UNEXP]   = s_rreq_valid && !(pv && pa);
    e[ERR_RESP_NO_LAST] = rbeat && (r_next == 0) && !s_rreq_attr[ATTR_LAST];
    e[ERR_RESP_ID]      = s_rreq_valid && r_in && (s_rreq_id != m_rid);
    e[ERR_RESP_STALL]   = s_rreq_stall;
    if (rbeat && !r_in && pv && pr) m_rid = s_rreq_id;
    m_rrem = r_next;
    if (wstart) begin
      m_wrem = (bc != 0) ? bc - 1 : 0;
      m_wid  = s_creq_id;
    end else if (wbeat && w_in) begin
      m_wrem = m_wrem - 1;
    end
    if (s_creq_valid) begin
      m_vld[s_creq_id]  = 1'b1;
      m_ack[s_creq_id]  = s_creq_attr[CMD_ACK];
      m_rd[s_creq_id]   = (s_creq_type == TYPE_READ);
      m_bcnt[s_creq_id] = bc;
    end
  endtask

  // Check the previous cycle's pulse, then start a fresh input cycle
  task automatic begin_cycle();
    @(negedge clk);
    if (have_exp) begin
      assert (err_pulse === exp_q) else stop_on_mismatch(exp_name, exp_q, err_pulse);
    end
    clear_inputs();
  endtask

  task automatic end_cycle();
    logic [NUM_ERR-1:0] e;
    model_step(e);
    exp_q     = e;
    exp_name  = phase_name;
    have_exp  = 1'b1;
    seen_bits = seen_bits | e;
    if (e != 0) model_count++;
  endtask

  task automatic send_burst_beats();
    if (gen_wrem > 0) begin
      s_dreq_valid = 1'b1;
      s_dreq_id    = gen_wid;
      s_dreq_attr[ATTR_LAST] = (gen_wrem == 1);
      gen_wrem--;
    end
    if (gen_rrem > 0) begin
      s_rreq_valid = 1'b1;
      s_rreq_id    = gen_rid;
      s_rreq_attr[ATTR_LAST] = (gen_rrem == 1);
      gen_rrem--;
    end
  endtask

  // Mode 0 legal, 1 data faults, 2 response faults, 3 anything
  task automatic drive_random(input int mode);
    int beats;
    int ofs;
    logic [ID_W-1:0] id;
    begin_cycle();
    if (gen_rrem > 0 || (gen_wrem > 0 && $urandom % 4 != 0)) send_burst_beats();
    if (s_dreq_valid && mode % 2 == 1) begin
      if ($urandom % 6 == 0) s_dreq_id = gen_wid ^ 5'd1;
      if (s_dreq_attr[ATTR_LAST] && $urandom % 4 == 0) s_dreq_attr[ATTR_LAST] = 1'b0;
    end
    if (s_rreq_valid && mode >= 2) begin
      if ($urandom % 6 == 0) s_rreq_id = gen_rid ^ 5'd1;
      if ($urandom % 6 == 0) s_rreq_attr[ATTR_LAST] = !s_rreq_attr[ATTR_LAST];
    end else if (!s_rreq_valid && $urandom % 4 == 0) begin
      id = ID_W'($urandom);
      beats = (m_vld[id] && m_ack[id] && m_rd[id] && m_bcnt[id] > 1) ? int'(m_bcnt[id]) : 1;
      if ((m_vld[id] && m_ack[id]) || mode >= 2) begin
        s_rreq_valid = 1'b1;
        s_rreq_id    = id;
        s_rreq_attr[ATTR_LAST] = (beats == 1);
        gen_rid  = id;
        gen_rrem = beats - 1;
      end
    end
    if (mode >= 2 && $urandom % 10 == 0) s_rreq_stall = 1'b1;
    if (!s_dreq_valid && $urandom % 3 == 0) begin
      s_creq_valid = 1'b1;
      s_creq_type  = TYPE_W'($urandom % 4);
      if (s_creq_type == TYPE_WRITE && gen_wrem > 0) s_creq_type = TYPE_READ;
      s_creq_id = ID_W'($urandom);
      while ((s_rreq_valid && s_creq_id == s_rreq_id) || (gen_rrem > 0 && s_creq_id == gen_rid))
        s_creq_id = s_creq_id + 1'b1;          // Keep the entry under response intact
      s_creq_attr = ATTR_W'($urandom % 4);
      s_creq_addr = ADDR_W'($urandom);
      if (s_creq_type == TYPE_FLUSH || s_creq_type == TYPE_INVAL) begin
        s_creq_addr[LINE_OFS_W-1:0] = '0;
        s_creq_attr[CMD_CACHE] = 1'b1;
      end
      if (s_creq_attr[CMD_CACHE]) s_creq_addr[ADDR_W-1 -: PREFIX_W] = '0;
      ofs = int'(s_creq_addr[LINE_OFS_W-1:0]);
      s_creq_size = SIZE_W'(1 + $urandom % (LINE_BYTES - ofs));
      if (mode == 3 && $urandom % 5 == 0) begin
        s_creq_type = TYPE_W'($urandom);
        s_creq_size = SIZE_W'($urandom);
        s_creq_attr = ATTR_W'($urandom);
      end
      if (s_creq_type == TYPE_WRITE) begin
        beats = (int'(s_creq_addr[BYTE_OFS_W-1:0]) + int'(s_creq_size) + BEAT_BYTES - 1)
                / BEAT_BYTES;
        s_dreq_valid = 1'b1;
        s_dreq_id    = s_creq_id;
        s_dreq_attr[ATTR_LAST] = (beats == 1) && !(mode % 2 == 1 && $urandom % 4 == 0);
        gen_wid  = s_creq_id;
        gen_wrem = beats - 1;
      end
    end
    if (mode == 3 && $urandom % 12 == 0)
      {s_creq_rdstall, s_creq_wrstall, s_dreq_stall} = 3'($urandom);
    if (mode == 3 && $urandom % 10 == 0) begin
      s_dreq_valid = 1'b1;
      s_dreq_id    = ID_W'($urandom);
    end
    end_cycle();
    if (mode == 0) begin
      assert (exp_q == '0) else stop_with_message("Legal traffic generator made an illegal cycle");
    end
  endtask

  // One command rule broken at a time on an otherwise legal read
  task automatic inject_cmd(input int k);
    begin_cycle();
    s_creq_valid = 1'b1;
    s_creq_type  = TYPE_READ;
    s_creq_id    = ID_W'($urandom);
    s_creq_addr  = ADDR_W'($urandom) & ~ADDR_W'(LINE_BYTES - 1);
    s_creq_addr[ADDR_W-1 -: PREFIX_W] = '0;
    s_creq_size  = SIZE_W'(BEAT_BYTES);
    case (k)
      ERR_TYPE:           s_creq_type = TYPE_W'(4 + $urandom % 4);
      ERR_WR_NO_DATA:     s_creq_type = TYPE_WRITE;
      ERR_DATA_NONWR:     s_dreq_valid = 1'b1;
      ERR_MAINT_ALIGN: begin
        s_creq_type = TYPE_FLUSH;
        s_creq_attr[CMD_CACHE] = 1'b1;
        s_creq_addr[LINE_OFS_W-1:0] = LINE_OFS_W'(BEAT_BYTES);
      end
      ERR_MAINT_UNCACHED: s_creq_type = TYPE_INVAL;
      ERR_PREFIX: begin
        s_creq_attr[CMD_CACHE] = 1'b1;
        s_creq_addr[ADDR_W-1 -: PREFIX_W] = PREFIX_W'(1 + $urandom % 3);
      end
      ERR_SIZE:           s_creq_size = ($urandom % 2 == 0) ? '0 : SIZE_W'(LINE_BYTES + 8);
      default: begin
        s_creq_valid   = 1'b0;
        s_creq_rdstall = 1'b1;                  // Only one of three stalls
      end
    endcase
    end_cycle();
    assert (exp_q == NUM_ERR'(1) << k) else stop_on_mismatch("command class", 1 << k, exp_q);
    begin_cycle();
    end_cycle();
  endtask

  task automatic drain_bursts();
    repeat (DRAIN_CYCLES) begin
      begin_cycle();
      send_burst_beats();
      end_cycle();
    end
  endtask

  initial begin
    void'($urandom(72));
    clk = 1'b0;
    rst = 1'b1;
    clear_inputs();
    {have_exp, model_count, gen_wrem, gen_rrem, seen_bits} = '0;
    {m_wrem, m_rrem, m_wid, m_rid, gen_wid, gen_rid} = '0;
    for (int i = 0; i < NUM_ID; i++) begin
      {m_vld[i], m_ack[i], m_rd[i], m_bcnt[i]} = '0;
    end
    repeat (2) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;

    phase_name = "legal traffic";
    repeat (LEGAL_CYCLES) drive_random(0);
    drain_bursts();
    assert (err_count === '0) else stop_on_mismatch("legal err_count", 0, err_count);
    assert (err_sticky === 1'b0) else stop_on_mismatch("legal err_sticky", 0, err_sticky);

    phase_name = "command rules";
    for (int k = ERR_TYPE; k <= ERR_STALL_MIX; k++) inject_cmd(k);

    phase_name = "write data faults";
    repeat (DATA_CYCLES) drive_random(1);
    drain_bursts();
    phase_name = "response faults";
    repeat (RESP_CYCLES) drive_random(2);
    drain_bursts();
    assert (&seen_bits) else stop_with_message("Some error class was never exercised");

    phase_name = "mixed random";
    repeat (MIXED_CYCLES) drive_random(3);
    drain_bursts();
    begin_cycle();
    assert (err_count === CNT_W'(model_count))
      else stop_on_mismatch("error count", model_count, err_count);
    assert (err_sticky === (model_count != 0))
      else stop_on_mismatch("sticky flag", model_count != 0, err_sticky);
    $display("TEST OK");
    $finish;
  end

endmodule

//--- verilog/naxi_cmd_check.sv
`timescale 1ns/1ps

module naxi_cmd_check (
  input  logic                                             clk,
  input  logic                                             rst,
  input  logic                                             s_creq_valid,
  input  logic [naxi_pkg::TYPE_W-1:0]                      s_creq_type,
  input  logic [naxi_pkg::ATTR_W-1:0]                      s_creq_attr,
  input  logic [naxi_pkg::SIZE_W-1:0]                      s_creq_size,
  input  logic [naxi_pkg::ID_W-1:0]                        s_creq_id,
  input  logic [naxi_pkg::ADDR_W-1:0]                      s_creq_addr,
  input  logic                                             s_creq_rdstall,
  input  logic                                             s_creq_wrstall,
  input  logic                                             s_dreq_valid,
  input  logic [naxi_pkg::ID_W-1:0]                        s_dreq_id,
  input  logic                                             s_dreq_stall,
  output logic [naxi_pkg::BCNT_W-1:0]                      cmd_bcnt,
  output logic                                             wr_start,
  output logic [naxi_pkg::ERR_STALL_MIX:naxi_pkg::ERR_TYPE] cmd_err
);

  import naxi_pkg::*;

  logic              is_write;
  logic              is_maint;
  logic              any_stall;
  logic              all_stall;
  logic [SIZE_W:0]   beat_end;      // Byte offset in beat plus size
  logic [SIZE_W:0]   beat_round;
  logic [SIZE_W:0]   line_end;      // Byte offset in line plus size

  assign is_write  = (s_creq_type == TYPE_WRITE);
  assign is_maint  = (s_creq_type == TYPE_FLUSH) || (s_creq_type == TYPE_INVAL);
  assign any_stall = s_creq_rdstall || s_creq_wrstall || s_dreq_stall;
  assign all_stall = s_creq_rdstall && s_creq_wrstall && s_dreq_stall;

  // --------------------------------------------------------------------------
  // Beat count, ceil((offset + size) / BEAT_BYTES)
  // --------------------------------------------------------------------------
  assign beat_end   = {1'b0, s_creq_size} + (SIZE_W+1)'(s_creq_addr[BYTE_OFS_W-1:0]);
  assign beat_round = beat_end + (SIZE_W+1)'(BEAT_BYTES - 1);
  assign cmd_bcnt   = beat_round[BYTE_OFS_W+BCNT_W-1:BYTE_OFS_W];  // Exact for legal sizes

  assign line_end = {1'b0, s_creq_size} + (SIZE_W+1)'(s_creq_addr[LINE_OFS_W-1:0]);

  assign wr_start = s_creq_valid && is_write && s_dreq_valid && !any_stall;

  // --------------------------------------------------------------------------
  // Command rules
  // --------------------------------------------------------------------------
  always_comb begin
    cmd_err = '0;
    if (s_creq_valid) begin
      cmd_err[ERR_TYPE]           = (s_creq_type > TYPE_INVAL);
      cmd_err[ERR_WR_NO_DATA]     = is_write && !(s_dreq_valid && (s_dreq_id == s_creq_id));
      cmd_err[ERR_DATA_NONWR]     = !is_write && s_dreq_valid;
      cmd_err[ERR_MAINT_ALIGN]    = is_maint && (s_creq_addr[LINE_OFS_W-1:0] != '0);
      cmd_err[ERR_MAINT_UNCACHED] = is_maint && !s_creq_attr[CMD_CACHE];
      cmd_err[ERR_PREFIX]         = s_creq_attr[CMD_CACHE] &&
                                    (s_creq_addr[ADDR_W-1 -: PREFIX_W] != '0);
      // Line end past the line also catches oversize requests
      cmd_err[ERR_SIZE]           = (s_creq_size == '0) ||
                                    (line_end > (SIZE_W+1)'(LINE_BYTES));
    end
    cmd_err[ERR_STALL_MIX] = any_stall && !all_stall;  // Checked every cycle
  end

  a_bcnt_in_line: assert property (@(posedge clk) disable iff (rst)
      (s_creq_valid && !cmd_err[ERR_SIZE]) |-> (cmd_bcnt <= BCNT_W'(LINE_BEATS)))
    else $error("beat count %0d beyond a line on a legal size", cmd_bcnt);

endmodule

//--- verilog/naxi_error_log.sv
`timescale 1ns/1ps

module naxi_error_log (
  input  logic                                                      clk,
  input  logic                                                      rst,
  input  logic [naxi_pkg::ERR_STALL_MIX:naxi_pkg::ERR_TYPE]         cmd_err,
  input  logic [naxi_pkg::ERR_DATA_ID:naxi_pkg::ERR_DATA_NO_LAST]   data_err,
  input  logic [naxi_pkg::ERR_RESP_STALL:naxi_pkg::ERR_RESP_UNEXP]  resp_err,
  output logic [naxi_pkg::NUM_ERR-1:0]                              err_pulse,
  output logic                                                      err_sticky,
  output logic [naxi_pkg::CNT_W-1:0]                                err_count
);

  import naxi_pkg::*;

  logic [NUM_ERR-1:0] err_vec;
  logic               err_any;

  assign err_vec = {resp_err, data_err, cmd_err};
  assign err_any = |err_vec;

  always_ff @(posedge clk) begin
    if (rst) begin
      err_pulse <= '0;
    end else begin
      err_pulse <= err_vec;         // One cycle per erroneous cycle
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      err_sticky <= 1'b0;
    end else if (err_any) begin
      err_sticky <= 1'b1;
    end
  end

  // Saturating count of cycles with any error
  always_ff @(posedge clk) begin
    if (rst) begin
      err_count <= '0;
    end else if (err_any && (err_count != '1)) begin
      err_count <= err_count + 1'b1;
    end
  end

endmodule

//--- verilog/naxi_pending_table.sv
`timescale 1ns/1ps

module naxi_pending_table (
  input  logic                        clk,
  input  logic                        rst,
  input  logic                        s_creq_valid,
  input  logic [naxi_pkg::ID_W-1:0]   s_creq_id,
  input  logic [naxi_pkg::TYPE_W-1:0] s_creq_type,
  input  logic [naxi_pkg::ATTR_W-1:0] s_creq_attr,
  input  logic [naxi_pkg::BCNT_W-1:0] cmd_bcnt,
  input  logic [naxi_pkg::ID_W-1:0]   s_rreq_id,
  output logic                        pend_valid,
  output logic                        pend_ack,
  output logic                        pend_rd,
  output logic [naxi_pkg::BCNT_W-1:0] pend_bcnt
);

  import naxi_pkg::*;

  logic [NUM_ID-1:0] vld_q;
  logic [NUM_ID-1:0] ack_q;
  logic [NUM_ID-1:0] rd_q;
  logic [BCNT_W-1:0] bcnt_q [NUM_ID];

  always_ff @(posedge clk) begin
    if (rst) begin
      vld_q <= '0;
    end else if (s_creq_valid) begin
      vld_q[s_creq_id] <= 1'b1;
    end
  end

  // New command replaces whatever was pending on its ID
  always_ff @(posedge clk) begin
    if (s_creq_valid) begin
      ack_q[s_creq_id]  <= s_creq_attr[CMD_ACK];
      rd_q[s_creq_id]   <= (s_creq_type == TYPE_READ);
      bcnt_q[s_creq_id] <= cmd_bcnt;
    end
  end

  assign pend_valid = vld_q[s_rreq_id];
  assign pend_ack   = ack_q[s_rreq_id];
  assign pend_rd    = rd_q[s_rreq_id];
  assign pend_bcnt  = bcnt_q[s_rreq_id];

endmodule

//--- verilog/naxi_pkg.sv
package naxi_pkg;

  // --------------------------------------------------------------------------
  // Bus field widths
  // --------------------------------------------------------------------------
  localparam int ID_W       = 5;
  localparam int NUM_ID     = 32;
  localparam int TYPE_W     = 3;
  localparam int ATTR_W     = 3;
  localparam int SIZE_W     = 8;   // Size in bytes
  localparam int ADDR_W     = 26;
  localparam int PREFIX_W   = 2;   // Must be zero for cacheable requests
  localparam int BEAT_BYTES = 8;
  localparam int BYTE_OFS_W = 3;
  localparam int LINE_BEATS = 4;
  localparam int LINE_BYTES = 32;
  localparam int LINE_OFS_W = 5;
  localparam int BCNT_W     = 3;

  // Command types
  localparam logic [TYPE_W-1:0] TYPE_WRITE = 3'd0;
  localparam logic [TYPE_W-1:0] TYPE_READ  = 3'd1;
  localparam logic [TYPE_W-1:0] TYPE_FLUSH = 3'd2;
  localparam logic [TYPE_W-1:0] TYPE_INVAL = 3'd3;

  // Attribute bit positions
  localparam int CMD_ACK   = 0;    // Command wants a response
  localparam int CMD_CACHE = 1;    // Cacheable request
  localparam int ATTR_LAST = 0;    // Data and response last beat

  // --------------------------------------------------------------------------
  // Error vector layout
  // --------------------------------------------------------------------------
  localparam int ERR_TYPE           = 0;
  localparam int ERR_WR_NO_DATA     = 1;
  localparam int ERR_DATA_NONWR     = 2;
  localparam int ERR_MAINT_ALIGN    = 3;
  localparam int ERR_MAINT_UNCACHED = 4;
  localparam int ERR_PREFIX         = 5;
  localparam int ERR_SIZE           = 6;
  localparam int ERR_STALL_MIX      = 7;
  localparam int ERR_DATA_NO_LAST   = 8;
  localparam int ERR_DATA_ID        = 9;
  localparam int ERR_RESP_UNEXP     = 10;
  localparam int ERR_RESP_NO_LAST   = 11;
  localparam int ERR_RESP_ID        = 12;
  localparam int ERR_RESP_STALL     = 13;
  localparam int NUM_ERR            = 14;

  localparam int CNT_W = 16;       // Error cycle counter

endpackage

//--- verilog/naxi_protocol_monitor.sv
`timescale 1ns/1ps

module naxi_protocol_monitor (
  input  logic                          clk,
  input  logic                          rst,
  input  logic                          s_creq_valid,
  input  logic [naxi_pkg::TYPE_W-1:0]   s_creq_type,
  input  logic [naxi_pkg::ATTR_W-1:0]   s_creq_attr,
  input  logic [naxi_pkg::SIZE_W-1:0]   s_creq_size,
  input  logic [naxi_pkg::ID_W-1:0]     s_creq_id,
  input  logic [naxi_pkg::ADDR_W-1:0]   s_creq_addr,
  input  logic                          s_creq_rdstall,
  input  logic                          s_creq_wrstall,
  input  logic                          s_dreq_valid,
  input  logic [naxi_pkg::ID_W-1:0]     s_dreq_id,
  input  logic [naxi_pkg::ATTR_W-1:0]   s_dreq_attr,
  input  logic                          s_dreq_stall,
  input  logic                          s_rreq_valid,
  input  logic [naxi_pkg::ID_W-1:0]     s_rreq_id,
  input  logic [naxi_pkg::ATTR_W-1:0]   s_rreq_attr,
  input  logic                          s_rreq_stall,
  output logic [naxi_pkg::NUM_ERR-1:0]  err_pulse,
  output logic                          err_sticky,
  output logic [naxi_pkg::CNT_W-1:0]    err_count
);

  import naxi_pkg::*;

  logic [BCNT_W-1:0]                      cmd_bcnt;
  logic                                   wr_start;
  logic                                   pend_valid;
  logic                                   pend_ack;
  logic                                   pend_rd;
  logic [BCNT_W-1:0]                      pend_bcnt;
  logic [ERR_STALL_MIX:ERR_TYPE]          cmd_err;
  logic [ERR_DATA_ID:ERR_DATA_NO_LAST]    data_err;
  logic [ERR_RESP_STALL:ERR_RESP_UNEXP]   resp_err;

  naxi_cmd_check u_cmd_check (
    .clk, .rst,
    .s_creq_valid, .s_creq_type, .s_creq_attr, .s_creq_size, .s_creq_id, .s_creq_addr,
    .s_creq_rdstall, .s_creq_wrstall,
    .s_dreq_valid, .s_dreq_id, .s_dreq_stall,
    .cmd_bcnt, .wr_start, .cmd_err
  );

  naxi_pending_table u_pending_table (
    .clk, .rst,
    .s_creq_valid, .s_creq_id, .s_creq_type, .s_creq_attr, .cmd_bcnt,
    .s_rreq_id,
    .pend_valid, .pend_ack, .pend_rd, .pend_bcnt
  );

  naxi_wdata_track u_wdata_track (
    .clk, .rst,
    .wr_start, .s_creq_id, .cmd_bcnt,
    .s_dreq_valid, .s_dreq_id, .s_dreq_attr, .s_dreq_stall,
    .data_err
  );

  naxi_resp_track u_resp_track (
    .clk, .rst,
    .s_rreq_valid, .s_rreq_id, .s_rreq_attr, .s_rreq_stall,
    .pend_valid, .pend_ack, .pend_rd, .pend_bcnt,
    .resp_err
  );

  naxi_error_log u_error_log (
    .clk, .rst,
    .cmd_err, .data_err, .resp_err,
    .err_pulse, .err_sticky, .err_count
  );

endmodule

//--- verilog/naxi_resp_track.sv
`timescale 1ns/1ps

module naxi_resp_track (
  input  logic                                                      clk,
  input  logic                                                      rst,
  input  logic                                                      s_rreq_valid,
  input  logic [naxi_pkg::ID_W-1:0]                                 s_rreq_id,
  input  logic [naxi_pkg::ATTR_W-1:0]                               s_rreq_attr,
  input  logic                                                      s_rreq_stall,
  input  logic                                                      pend_valid,
  input  logic                                                      pend_ack,
  input  logic                                                      pend_rd,
  input  logic [naxi_pkg::BCNT_W-1:0]                               pend_bcnt,
  output logic [naxi_pkg::ERR_RESP_STALL:naxi_pkg::ERR_RESP_UNEXP] resp_err
);

  import naxi_pkg::*;

  logic [BCNT_W-1:0] rem_q;
  logic [BCNT_W-1:0] rem_nxt;
  logic [ID_W-1:0]   rsp_id_q;
  logic [ID_W-1:0]   rsp_id_nxt;
  logic              beat;
  logic              in_burst;

  assign beat     = s_rreq_valid && !s_rreq_stall;
  assign in_burst = (rem_q != '0);

  // --------------------------------------------------------------------------
  // Read response beat counting
  // --------------------------------------------------------------------------
  always_comb begin
    rem_nxt    = rem_q;
    rsp_id_nxt = rsp_id_q;
    if (beat && !in_burst) begin
      rem_nxt = '0;                             // Non-read responses are one beat
      if (pend_valid && pend_rd) begin
        rem_nxt    = (pend_bcnt != '0) ? pend_bcnt - 1'b1 : '0;
        rsp_id_nxt = s_rreq_id;
      end
    end else if (beat) begin
      rem_nxt = rem_q - 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      rem_q <= '0;
    end else begin
      rem_q <= rem_nxt;
    end
  end

  always_ff @(posedge clk) begin
    rsp_id_q <= rsp_id_nxt;
  end

  // --------------------------------------------------------------------------
  // Response rules
  // --------------------------------------------------------------------------
  assign resp_err[ERR_RESP_UNEXP]   = s_rreq_valid && !(pend_valid && pend_ack);
  assign resp_err[ERR_RESP_NO_LAST] = beat && (rem_nxt == '0) && !s_rreq_attr[ATTR_LAST];
  assign resp_err[ERR_RESP_ID]      = s_rreq_valid && in_burst && (s_rreq_id != rsp_id_q);
  assign resp_err[ERR_RESP_STALL]   = s_rreq_stall;  // Slave response never stalls

endmodule

//--- verilog/naxi_wdata_track.sv
`timescale 1ns/1ps

module naxi_wdata_track (
  input  logic                                                     clk,
  input  logic                                                     rst,
  input  logic                                                     wr_start,
  input  logic [naxi_pkg::ID_W-1:0]                                s_creq_id,
  input  logic [naxi_pkg::BCNT_W-1:0]                              cmd_bcnt,
  input  logic                                                     s_dreq_valid,
  input  logic [naxi_pkg::ID_W-1:0]                                s_dreq_id,
  input  logic [naxi_pkg::ATTR_W-1:0]                              s_dreq_attr,
  input  logic                                                     s_dreq_stall,
  output logic [naxi_pkg::ERR_DATA_ID:naxi_pkg::ERR_DATA_NO_LAST] data_err
);

  import naxi_pkg::*;

  logic [BCNT_W-1:0] rem_q;         // Beats still owed after the current one
  logic [ID_W-1:0]   wr_id_q;
  logic              beat;
  logic              in_burst;
  logic              final_beat;

  assign beat     = s_dreq_valid && !s_dreq_stall;
  assign in_burst = (rem_q != '0);

  always_ff @(posedge clk) begin
    if (rst) begin
      rem_q <= '0;
    end else if (wr_start) begin
      rem_q <= (cmd_bcnt != '0) ? cmd_bcnt - 1'b1 : '0;  // First beat is this cycle
    end else if (beat && in_burst) begin
      rem_q <= rem_q - 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (wr_start) begin
      wr_id_q <= s_creq_id;
    end
  end

  // A beat in a wr_start cycle belongs to the new command
  assign final_beat = wr_start ? (cmd_bcnt == BCNT_W'(1)) : (rem_q == BCNT_W'(1));

  assign data_err[ERR_DATA_NO_LAST] = beat && final_beat && !s_dreq_attr[ATTR_LAST];
  assign data_err[ERR_DATA_ID]      = s_dreq_valid && in_burst && !wr_start &&
                                      (s_dreq_id != wr_id_q);

  a_wr_rem_no_wrap: assert property (@(posedge clk) disable iff (rst)
      ((rem_q == '0) && !wr_start) |=> (rem_q == '0))
    else $error("write beat count left zero without a new burst");

endmodule
